// File: Makefile
SIM := obj_dir/sim_fp_adder

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ps --top-module tb_fp_adder \
		-f files.f --Mdir obj_dir -o sim_fp_adder

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/fp_add_pkg.sv
`default_nettype none

package fp_add_pkg;

  // binary32 field widths
  localparam int EXP_W   = 8;
  localparam int FRAC_W  = 23;

  // working widths of the datapath
  localparam int SIG_W   = FRAC_W + 1;
  localparam int EXT_W   = SIG_W + 3;
  localparam int SUM_W   = EXT_W + 1;
  localparam int LZC_W   = 5;

  localparam int EXP_MAX = 255;

  typedef logic [EXP_W-1:0]  exp_t;
  typedef logic [FRAC_W-1:0] frac_t;
  // hidden bit, fraction, guard, round, sticky
  typedef logic [EXT_W-1:0]  ext_sig_t;
  typedef logic [SUM_W-1:0]  sum_t;
  typedef logic [LZC_W-1:0]  lzc_t;

  // canonical quiet NaN mantissa, hidden bit and quiet bit set
  localparam ext_sig_t QNAN_MANT = {2'b11, {(EXT_W-2){1'b0}}};
  // infinity mantissa carries only the hidden bit
  localparam ext_sig_t INF_MANT  = {1'b1, {(EXT_W-1){1'b0}}};

  typedef enum logic [2:0] {
    CLS_ZERO,
    CLS_SUB,
    CLS_NORM,
    CLS_INF,
    CLS_QNAN,
    CLS_SNAN
  } fp_class_e;

endpackage

`default_nettype wire

// File: files.f
common/fp_add_pkg.sv
hdl/fp_classify.sv
fp_add/fp_align.sv
fp_add/fp_mag_addsub.sv
fp_add/fp_normalize.sv
hdl/fp_result_select.sv
hdl/fp_adder_top.sv
verification/fp_adder_checker.sv
verification/tb_fp_adder.sv

// File: fp_add/fp_align.sv
`timescale 1ns/1ps
`default_nettype none

module fp_align
  import fp_add_pkg::*;
(
  input  wire       sign_a_i,
  input  wire       sign_b_i,
  input  wire exp_t exp_a_i,
  input  wire exp_t exp_b_i,
  input  wire frac_t frac_a_i,
  input  wire frac_t frac_b_i,
  input  wire       sub_a_i,
  input  wire       sub_b_i,
  output logic      big_sign_o,
  output logic      small_sign_o,
  output exp_t      big_exp_o,
  output ext_sig_t  big_sig_o,
  output ext_sig_t  small_sig_o
);

  exp_t             eff_exp_a;
  exp_t             eff_exp_b;
  logic [SIG_W-1:0] sig_a;
  logic [SIG_W-1:0] sig_b;
  logic             a_is_big;
  exp_t             small_exp;
  exp_t             exp_diff;
  ext_sig_t         small_ext;
  ext_sig_t         lost_mask;

  // subnormals sit at exponent 1 without the hidden bit
  assign eff_exp_a = sub_a_i ? exp_t'(1) : exp_a_i;
  assign eff_exp_b = sub_b_i ? exp_t'(1) : exp_b_i;
  assign sig_a     = {(exp_a_i != '0), frac_a_i};
  assign sig_b     = {(exp_b_i != '0), frac_b_i};

  assign a_is_big  = (eff_exp_a > eff_exp_b) ||
                     ((eff_exp_a == eff_exp_b) && (sig_a >= sig_b));

  assign big_sign_o   = a_is_big ? sign_a_i : sign_b_i;
  assign small_sign_o = a_is_big ? sign_b_i : sign_a_i;
  assign big_exp_o    = a_is_big ? eff_exp_a : eff_exp_b;
  assign small_exp    = a_is_big ? eff_exp_b : eff_exp_a;
  assign big_sig_o    = a_is_big ? {sig_a, 3'b000} : {sig_b, 3'b000};
  assign small_ext    = a_is_big ? {sig_b, 3'b000} : {sig_a, 3'b000};

  assign exp_diff  = big_exp_o - small_exp;
  assign lost_mask = ~({EXT_W{1'b1}} << exp_diff);

  // right shift, everything that falls off lands in the sticky bit
  always_comb
  begin
    if (exp_diff >= exp_t'(EXT_W))
    begin
      small_sig_o = {{(EXT_W-1){1'b0}}, (small_ext != '0)};
    end
    else
    begin
      small_sig_o    = small_ext >> exp_diff;
      small_sig_o[0] = small_sig_o[0] | ((small_ext & lost_mask) != '0);
    end
  end

endmodule

`default_nettype wire

// File: fp_add/fp_mag_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mag_addsub
  import fp_add_pkg::*;
(
  input  wire           big_sign_i,
  input  wire           small_sign_i,
  input  wire ext_sig_t big_sig_i,
  input  wire ext_sig_t small_sig_i,
  output sum_t          raw_sum_o,
  output logic          raw_sign_o,
  output logic          cancel_o
);

  logic eff_sub;
  sum_t big_ext;
  sum_t small_ext;

  assign eff_sub   = big_sign_i ^ small_sign_i;
  assign big_ext   = {1'b0, big_sig_i};
  assign small_ext = {1'b0, small_sig_i};

  // big magnitude is never below small, so the difference stays positive
  always_comb
  begin
    if (eff_sub)
    begin
      raw_sum_o = big_ext - small_ext;
    end
    else
    begin
      raw_sum_o = big_ext + small_ext;
    end
  end

  assign raw_sign_o = big_sign_i;

  // exact zero difference, sticky included
  assign cancel_o = eff_sub && (big_sig_i == small_sig_i);

endmodule

`default_nettype wire

// File: fp_add/fp_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module fp_normalize
  import fp_add_pkg::*;
(
  input  wire sum_t raw_sum_i,
  input  wire exp_t big_exp_i,
  output exp_t      norm_exp_o,
  output ext_sig_t  norm_mant_o,
  output logic      overflow_o
);

  logic     carry;
  exp_t     exp_inc;
  ext_sig_t mant_low;
  lzc_t     lzc;
  exp_t     shift_limit;
  lzc_t     shift;
  ext_sig_t mant_shl;

  assign carry    = raw_sum_i[SUM_W-1];
  assign exp_inc  = big_exp_i + exp_t'(1);
  assign mant_low = raw_sum_i[EXT_W-1:0];

  // leading zero count, highest set bit wins
  always_comb
  begin
    lzc = lzc_t'(EXT_W);
    for (int i = 0; i < EXT_W; i++)
    begin
      if (mant_low[i])
      begin
        lzc = lzc_t'(EXT_W - 1 - i);
      end
    end
  end

  // never shift below exponent 1
  assign shift_limit = (big_exp_i == '0) ? '0 : big_exp_i - exp_t'(1);
  assign shift       = ({{(EXP_W-LZC_W){1'b0}}, lzc} > shift_limit) ?
                       shift_limit[LZC_W-1:0] : lzc;
  assign mant_shl    = mant_low << shift;

  always_comb
  begin
    if (carry)
    begin
      // fold the two dropped bits into sticky
      norm_mant_o = {raw_sum_i[SUM_W-1:2], raw_sum_i[1] | raw_sum_i[0]};
      norm_exp_o  = exp_inc;
    end
    else
    begin
      norm_mant_o = mant_shl;
      norm_exp_o  = big_exp_i - {{(EXP_W-LZC_W){1'b0}}, shift};
      // hidden bit still clear means a subnormal result
      if (!mant_shl[EXT_W-1])
      begin
        norm_exp_o = '0;
      end
    end
  end

  assign overflow_o = carry && (exp_inc == exp_t'(EXP_MAX));

endmodule

`default_nettype wire

// File: hdl/fp_adder_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_adder_top
  import fp_add_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_n_i,
  input  wire        in_valid_i,
  input  wire        sign_a_i,
  input  wire        sign_b_i,
  input  wire exp_t  exp_a_i,
  input  wire exp_t  exp_b_i,
  input  wire frac_t frac_a_i,
  input  wire frac_t frac_b_i,
  output logic       out_valid_o,
  output logic       out_sign_o,
  output logic       invalid_o,
  output exp_t       out_exp_o,
  output ext_sig_t   out_mant_o
);

  fp_class_e class_a;
  fp_class_e class_b;
  logic      sub_a;
  logic      sub_b;
  logic      big_sign;
  logic      small_sign;
  exp_t      big_exp;
  ext_sig_t  big_sig;
  ext_sig_t  small_sig;
  sum_t      raw_sum;
  logic      raw_sign;
  logic      cancel;
  exp_t      norm_exp;
  ext_sig_t  norm_mant;
  logic      overflow;

  fp_classify fp_classify_a_i (
    .exp_i   (exp_a_i),
    .frac_i  (frac_a_i),
    .class_o (class_a)
  );

  fp_classify fp_classify_b_i (
    .exp_i   (exp_b_i),
    .frac_i  (frac_b_i),
    .class_o (class_b)
  );

  assign sub_a = (class_a == CLS_SUB);
  assign sub_b = (class_b == CLS_SUB);

  fp_align fp_align_i (
    .sign_a_i     (sign_a_i),
    .sign_b_i     (sign_b_i),
    .exp_a_i      (exp_a_i),
    .exp_b_i      (exp_b_i),
    .frac_a_i     (frac_a_i),
    .frac_b_i     (frac_b_i),
    .sub_a_i      (sub_a),
    .sub_b_i      (sub_b),
    .big_sign_o   (big_sign),
    .small_sign_o (small_sign),
    .big_exp_o    (big_exp),
    .big_sig_o    (big_sig),
    .small_sig_o  (small_sig)
  );

  fp_mag_addsub fp_mag_addsub_i (
    .big_sign_i   (big_sign),
    .small_sign_i (small_sign),
    .big_sig_i    (big_sig),
    .small_sig_i  (small_sig),
    .raw_sum_o    (raw_sum),
    .raw_sign_o   (raw_sign),
    .cancel_o     (cancel)
  );

  fp_normalize fp_normalize_i (
    .raw_sum_i   (raw_sum),
    .big_exp_i   (big_exp),
    .norm_exp_o  (norm_exp),
    .norm_mant_o (norm_mant),
    .overflow_o  (overflow)
  );

  fp_result_select fp_result_select_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .sign_a_i    (sign_a_i),
    .sign_b_i    (sign_b_i),
    .raw_sign_i  (raw_sign),
    .cancel_i    (cancel),
    .overflow_i  (overflow),
    .class_a_i   (class_a),
    .class_b_i   (class_b),
    .norm_exp_i  (norm_exp),
    .norm_mant_i (norm_mant),
    .out_valid_o (out_valid_o),
    .out_sign_o  (out_sign_o),
    .invalid_o   (invalid_o),
    .out_exp_o   (out_exp_o),
    .out_mant_o  (out_mant_o)
  );

endmodule

`default_nettype wire

// File: hdl/fp_classify.sv
`timescale 1ns/1ps
`default_nettype none

module fp_classify
  import fp_add_pkg::*;
(
  input  wire exp_t      exp_i,
  input  wire frac_t     frac_i,
  output fp_class_e      class_o
);

  logic exp_ones;
  logic exp_zero;
  logic frac_zero;

  assign exp_ones  = (exp_i == exp_t'(EXP_MAX));
  assign exp_zero  = (exp_i == '0);
  assign frac_zero = (frac_i == '0);

  // NaN checks come first, then infinity, zero and subnormal
  always_comb
  begin
    if (exp_ones && !frac_zero && !frac_i[FRAC_W-1])
    begin
      class_o = CLS_SNAN;
    end
    else if (exp_ones && frac_i[FRAC_W-1])
    begin
      class_o = CLS_QNAN;
    end
    else if (exp_ones)
    begin
      class_o = CLS_INF;
    end
    else if (exp_zero && frac_zero)
    begin
      class_o = CLS_ZERO;
    end
    else if (exp_zero)
    begin
      class_o = CLS_SUB;
    end
    else
    begin
      class_o = CLS_NORM;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fp_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module fp_result_select
  import fp_add_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_n_i,
  input  wire            in_valid_i,
  input  wire            sign_a_i,
  input  wire            sign_b_i,
  input  wire            raw_sign_i,
  input  wire            cancel_i,
  input  wire            overflow_i,
  input  wire fp_class_e class_a_i,
  input  wire fp_class_e class_b_i,
  input  wire exp_t      norm_exp_i,
  input  wire ext_sig_t  norm_mant_i,
  output logic           out_valid_o,
  output logic           out_sign_o,
  output logic           invalid_o,
  output exp_t           out_exp_o,
  output ext_sig_t       out_mant_o
);

  logic     nan_any;
  logic     inf_a;
  logic     inf_b;
  logic     inf_clash;
  logic     invalid_d;
  logic     sign_d;
  exp_t     exp_d;
  ext_sig_t mant_d;

  assign nan_any   = (class_a_i inside {CLS_QNAN, CLS_SNAN}) ||
                     (class_b_i inside {CLS_QNAN, CLS_SNAN});
  assign inf_a     = (class_a_i == CLS_INF);
  assign inf_b     = (class_b_i == CLS_INF);
  assign inf_clash = inf_a && inf_b && (sign_a_i != sign_b_i);
  assign invalid_d = (class_a_i == CLS_SNAN) || (class_b_i == CLS_SNAN) || inf_clash;

  // special cases in priority order
  always_comb
  begin
    sign_d = raw_sign_i;
    exp_d  = norm_exp_i;
    mant_d = norm_mant_i;
    if (nan_any || inf_clash)
    begin
      sign_d = 1'b1;
      exp_d  = exp_t'(EXP_MAX);
      mant_d = QNAN_MANT;
    end
    else if (inf_a || inf_b)
    begin
      sign_d = inf_a ? sign_a_i : sign_b_i;
      exp_d  = exp_t'(EXP_MAX);
      mant_d = INF_MANT;
    end
    else if ((class_a_i == CLS_ZERO) && (class_b_i == CLS_ZERO))
    begin
      sign_d = sign_a_i & sign_b_i;
      exp_d  = '0;
      mant_d = '0;
    end
    else if (cancel_i)
    begin
      sign_d = 1'b0;
      exp_d  = '0;
      mant_d = '0;
    end
    else if (overflow_i)
    begin
      exp_d  = exp_t'(EXP_MAX);
      mant_d = INF_MANT;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      out_valid_o <= 1'b0;
      invalid_o   <= 1'b0;
    end
    else
    begin
      out_valid_o <= in_valid_i;
      if (in_valid_i)
      begin
        invalid_o <= invalid_d;
      end
    end
  end

  // result payload, loaded on each strobe
  always_ff @(posedge clk_i)
  begin
    if (in_valid_i)
    begin
      out_sign_o <= sign_d;
      out_exp_o  <= exp_d;
      out_mant_o <= mant_d;
    end
  end

endmodule

`default_nettype wire

// File: verification/fp_adder_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fp_adder_checker
  import fp_add_pkg::*;
(
  input  wire           clk_i,
  input  wire           rst_n_i,
  input  wire [159:0]   test_name_i,
  input  wire           in_valid_i,
  input  wire           sign_a_i,
  input  wire           sign_b_i,
  input  wire exp_t     exp_a_i,
  input  wire exp_t     exp_b_i,
  input  wire frac_t    frac_a_i,
  input  wire frac_t    frac_b_i,
  input  wire           out_valid_i,
  input  wire           out_sign_i,
  input  wire           invalid_i,
  input  wire exp_t     out_exp_i,
  input  wire ext_sig_t out_mant_i,
  output int            check_count_o,
  output int            error_count_o,
  output int            pending_o
);

  // operand pair packed as {sign_a, exp_a, frac_a, sign_b, exp_b, frac_b}
  logic [63:0]  op_q[$];
  logic [159:0] name_q[$];
  logic [63:0]  op;
  logic [159:0] name;
  logic [36:0]  expected;
  logic [36:0]  actual;
  int           checks = 0;
  int           errors = 0;
  int           pending = 0;

  assign check_count_o = checks;
  assign error_count_o = errors;
  assign pending_o     = pending;

  // result packed as {invalid, sign, exponent, 27-bit mantissa}
  function automatic logic [36:0] fp_add_ref(input logic sa, input exp_t ea, input frac_t fa,
                                             input logic sb, input exp_t eb, input frac_t fb);
    logic        nan_a;
    logic        nan_b;
    logic        snan_any;
    logic        inf_a;
    logic        inf_b;
    logic        clash;
    logic        a_big;
    logic        rs;
    logic        sticky;
    logic [23:0] sig_a;
    logic [23:0] sig_b;
    logic [26:0] big_m;
    logic [26:0] small_m;
    logic [27:0] sum;
    logic [26:0] mant;
    int          ea_eff;
    int          eb_eff;
    int          big_e;
    int          diff;
    int          e;
    nan_a    = (ea == 8'hff) && (fa != '0);
    nan_b    = (eb == 8'hff) && (fb != '0);
    snan_any = (nan_a && !fa[22]) || (nan_b && !fb[22]);
    inf_a    = (ea == 8'hff) && (fa == '0);
    inf_b    = (eb == 8'hff) && (fb == '0);
    clash    = inf_a && inf_b && (sa != sb);
    if (nan_a || nan_b || clash)
    begin
      return {snan_any || clash, 1'b1, 8'hff, 27'h6000000};
    end
    if (inf_a || inf_b)
    begin
      return {1'b0, inf_a ? sa : sb, 8'hff, 27'h4000000};
    end
    if ((ea == '0) && (fa == '0) && (eb == '0) && (fb == '0))
    begin
      return {1'b0, sa & sb, 8'h00, 27'h0};
    end
    // zero and subnormal both sit at exponent 1 without a hidden bit
    ea_eff = (ea == '0) ? 1 : int'(ea);
    eb_eff = (eb == '0) ? 1 : int'(eb);
    sig_a  = {(ea != '0), fa};
    sig_b  = {(eb != '0), fb};
    a_big  = (ea_eff > eb_eff) || ((ea_eff == eb_eff) && (sig_a >= sig_b));
    big_m   = a_big ? {sig_a, 3'b000} : {sig_b, 3'b000};
    small_m = a_big ? {sig_b, 3'b000} : {sig_a, 3'b000};
    big_e   = a_big ? ea_eff : eb_eff;
    diff    = a_big ? (ea_eff - eb_eff) : (eb_eff - ea_eff);
    rs      = a_big ? sa : sb;
    sticky  = 1'b0;
    for (int i = 0; i < 254; i++)
    begin
      if (i < diff)
      begin
        sticky  = sticky | small_m[0];
        small_m = small_m >> 1;
      end
    end
    small_m[0] = small_m[0] | sticky;
    if (sa == sb)
    begin
      sum = {1'b0, big_m} + {1'b0, small_m};
    end
    else
    begin
      sum = {1'b0, big_m} - {1'b0, small_m};
    end
    if ((sa != sb) && (sum == '0))
    begin
      return {1'b0, 1'b0, 8'h00, 27'h0};
    end
    if (sum[27])
    begin
      e = big_e + 1;
      if (e == 255)
      begin
        return {1'b0, rs, 8'hff, 27'h4000000};
      end
      return {1'b0, rs, e[7:0], sum[27:2], sum[1] | sum[0]};
    end
    mant = sum[26:0];
    e    = big_e;
    // shift left one step at a time, never below exponent 1
    for (int i = 0; i < 27; i++)
    begin
      if (!mant[26] && (e > 1))
      begin
        mant = mant << 1;
        e    = e - 1;
      end
    end
    if (!mant[26])
    begin
      e = 0;
    end
    return {1'b0, rs, e[7:0], mant};
  endfunction

  // results of edge k are checked half a cycle later and new operands queued behind them
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      op_q.delete();
      name_q.delete();
    end
    else
    begin
      if (out_valid_i && (op_q.size() == 0))
      begin
        $display("a result was flagged valid with no operation outstanding");
        errors++;
      end
      else if (op_q.size() != 0)
      begin
        op   = op_q.pop_front();
        name = name_q.pop_front();
        if (!out_valid_i)
        begin
          $display("test %0s: result missing one cycle after its strobe", name);
          errors++;
        end
        else
        begin
          expected = fp_add_ref(op[63], op[62:55], op[54:32], op[31], op[30:23], op[22:0]);
          actual   = {invalid_i, out_sign_i, out_exp_i, out_mant_i};
          checks++;
          if (actual !== expected)
          begin
            $display("ERROR %0s: expected inv=%b s=%b e=%h m=%h, actual inv=%b s=%b e=%h m=%h",
                     name, expected[36], expected[35], expected[34:27], expected[26:0],
                     actual[36], actual[35], actual[34:27], actual[26:0]);
            errors++;
          end
        end
      end
      if (in_valid_i)
      begin
        op_q.push_back({sign_a_i, exp_a_i, frac_a_i, sign_b_i, exp_b_i, frac_b_i});
        name_q.push_back(test_name_i);
      end
    end
    pending = op_q.size();
  end

endmodule

`default_nettype wire

// File: verification/tb_fp_adder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_adder
  import fp_add_pkg::*;
();

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  logic         sign_a;
  logic         sign_b;
  exp_t         exp_a;
  exp_t         exp_b;
  frac_t        frac_a;
  frac_t        frac_b;
  logic         out_valid;
  logic         out_sign;
  logic         invalid;
  exp_t         out_exp;
  ext_sig_t     out_mant;
  logic [159:0] test_name;
  int           check_count;
  int           error_count;
  int           pending;
  int           tb_errors;
  int           tests;
  int           base_checks;
  int           base_errors;

  fp_adder_top fp_adder_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .exp_a_i     (exp_a),
    .exp_b_i     (exp_b),
    .frac_a_i    (frac_a),
    .frac_b_i    (frac_b),
    .out_valid_o (out_valid),
    .out_sign_o  (out_sign),
    .invalid_o   (invalid),
    .out_exp_o   (out_exp),
    .out_mant_o  (out_mant)
  );

  fp_adder_checker fp_adder_checker_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .test_name_i   (test_name),
    .in_valid_i    (in_valid),
    .sign_a_i      (sign_a),
    .sign_b_i      (sign_b),
    .exp_a_i       (exp_a),
    .exp_b_i       (exp_b),
    .frac_a_i      (frac_a),
    .frac_b_i      (frac_b),
    .out_valid_i   (out_valid),
    .out_sign_i    (out_sign),
    .invalid_i     (invalid),
    .out_exp_i     (out_exp),
    .out_mant_i    (out_mant),
    .check_count_o (check_count),
    .error_count_o (error_count),
    .pending_o     (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // one strobe per call with inputs changed 1 ns after the edge
  task automatic apply_op(input logic sa, input exp_t ea, input frac_t fa,
                          input logic sb, input exp_t eb, input frac_t fb);
    in_valid = 1'b1;
    sign_a   = sa;
    exp_a    = ea;
    frac_a   = fa;
    sign_b   = sb;
    exp_b    = eb;
    frac_b   = fb;
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input logic [159:0] name);
    test_name   = name;
    base_checks = check_count;
    base_errors = error_count + tb_errors;
  endtask

  task automatic end_test();
    int waited;
    waited   = 0;
    in_valid = 1'b0;
    while ((pending != 0) && (waited < 20))
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != 0)
    begin
      $display("test %0s: timed out waiting for results", test_name);
      tb_errors++;
    end
    else if (check_count == base_checks)
    begin
      $display("test %0s: no result was checked", test_name);
      tb_errors++;
    end
    tests++;
    $display("test %0s: %0d checks, %0d errors", test_name, check_count - base_checks,
             error_count + tb_errors - base_errors);
  endtask

  initial
  begin
    logic s;
    exp_t e0;
    exp_t e1;
    void'($urandom(32'h2f4f));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    exp_a     = '0;
    exp_b     = '0;
    frac_a    = '0;
    frac_b    = '0;
    tb_errors = 0;
    tests     = 0;
    test_name = "reset";

    // valid and invalid stay low for 5 reset cycles and 5 idle cycles after
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      #1;
      if ((out_valid !== 1'b0) || (invalid !== 1'b0))
      begin
        $display("out_valid or invalid was not low with no strobe given");
        tb_errors++;
      end
      if (i == 4)
      begin
        rst_n = 1'b1;
      end
    end
    tests++;
    $display("test reset: 0 checks, %0d errors", tb_errors);

    start_test("same_sign_add");
    for (int i = 0; i < 200; i++)
    begin
      s  = 1'($urandom);
      e0 = exp_t'(3 + ($urandom % 248));
      e1 = (i % 4 == 0) ? exp_t'(1 + ($urandom % 254)) : exp_t'(e0 + ($urandom % 5) - 2);
      apply_op(s, e0, frac_t'($urandom), s, e1, frac_t'($urandom));
    end
    end_test();

    start_test("opposite_sign_sub");
    for (int i = 0; i < 100; i++)
    begin
      s  = 1'($urandom);
      e0 = exp_t'(4 + ($urandom % 248));
      e1 = exp_t'(e0 + ($urandom % 7) - 3);
      apply_op(s, e0, frac_t'($urandom), ~s, e1, frac_t'($urandom));
    end
    // negative big operand, so only the cancellation rule gives +0
    apply_op(1'b1, 8'd130, 23'h2468ac, 1'b0, 8'd130, 23'h2468ac);
    apply_op(1'b0, 8'd150, 23'h400001, 1'b1, 8'd120, 23'h7fffff);
    apply_op(1'b1, 8'd140, 23'h000000, 1'b0, 8'd115, 23'h123457);
    end_test();

    start_test("zero_subnormal");
    apply_op(1'b0, 8'd0, 23'h0, 1'b0, 8'd0, 23'h0);
    apply_op(1'b0, 8'd0, 23'h0, 1'b1, 8'd0, 23'h0);
    apply_op(1'b1, 8'd0, 23'h0, 1'b0, 8'd0, 23'h0);
    apply_op(1'b1, 8'd0, 23'h0, 1'b1, 8'd0, 23'h0);
    apply_op(1'b1, 8'd0, 23'h0, 1'b0, 8'd100, 23'h2aaaaa);
    apply_op(1'b0, 8'd0, 23'h600000, 1'b0, 8'd0, 23'h500000);
    apply_op(1'b0, 8'd1, 23'h000010, 1'b1, 8'd1, 23'h000001);
    apply_op(1'b0, 8'd0, 23'h300000, 1'b1, 8'd0, 23'h100000);
    end_test();

    start_test("special_values");
    apply_op(1'b0, 8'd255, 23'h0, 1'b1, 8'd100, 23'h001234);
    apply_op(1'b1, 8'd255, 23'h0, 1'b1, 8'd255, 23'h0);
    apply_op(1'b0, 8'd255, 23'h0, 1'b1, 8'd255, 23'h0);
    apply_op(1'b0, 8'd255, 23'h400000, 1'b0, 8'd10, 23'h000001);
    apply_op(1'b1, 8'd0, 23'h0, 1'b0, 8'd255, 23'h000001);
    apply_op(1'b0, 8'd254, 23'h7fffff, 1'b0, 8'd254, 23'h7fffff);
    apply_op(1'b1, 8'd254, 23'h400000, 1'b1, 8'd254, 23'h400000);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, check_count, error_count + tb_errors);
    if ((error_count + tb_errors) == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
